// File: hdl/rv_wb_params.svh
`ifndef RV_WB_PARAMS_SVH
`define RV_WB_PARAMS_SVH

// integer data path width
`define RV_XLEN 64

// register file addressing
`define RV_REG_ADDR_W 5
`define RV_REG_COUNT 32

// store offset immediate
`define RV_IMM_W 32

`endif

// File: hdl/rv_wb_pkg.sv
`include "rv_wb_params.svh"

package rv_wb_pkg;

    typedef enum logic [1:0] {
        op_nop       = 2'd0,
        op_reg_write = 2'd1,
        op_store     = 2'd2,
        op_ebreak    = 2'd3
    } wb_op_e;

    typedef enum logic {
        src_alu = 1'b0,
        src_mem = 1'b1
    } wb_src_e;

    typedef enum logic [1:0] {
        ext_full   = 2'd0, // jalr, ld, add
        ext_word_s = 2'd1, // lw, addw
        ext_word_u = 2'd2, // lwu
        ext_half_s = 2'd3  // lh
    } wb_ext_e;

    typedef struct packed {
        wb_op_e                    op;
        wb_src_e                   src;
        wb_ext_e                   ext;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_REG_ADDR_W-1:0] rs_base; // store base register
        logic [`RV_IMM_W-1:0]      imm;
        logic [`RV_XLEN/8-1:0]     strb;
        logic [`RV_XLEN-1:0]       alu_res;
        logic [`RV_XLEN-1:0]       mem_res;
        logic [`RV_XLEN-1:0]       pc;
    } wb_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic                valid;
    } axil_aw_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   data;
        logic [`RV_XLEN/8-1:0] strb;
        logic                  valid;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       valid;
    } axil_b_t;

endpackage

// File: hdl/wb_extend.sv
`timescale 1ns/1ps
`include "rv_wb_params.svh"

module wb_extend (
    input  rv_wb_pkg::wb_src_e   src,
    input  rv_wb_pkg::wb_ext_e   ext,
    input  logic [`RV_XLEN-1:0]  alu_res,
    input  logic [`RV_XLEN-1:0]  mem_res,
    output logic [`RV_XLEN-1:0]  result
);

    logic [`RV_XLEN-1:0] sel; // chosen source before extension

    always_comb begin
        if (src == rv_wb_pkg::src_mem) begin
            sel = mem_res;
        end else begin
            sel = alu_res;
        end
    end

    always_comb begin
        case (ext)
            rv_wb_pkg::ext_full: begin
                result = sel;
            end
            rv_wb_pkg::ext_word_s: begin
                result = {{(`RV_XLEN-32){sel[31]}}, sel[31:0]};
            end
            rv_wb_pkg::ext_word_u: begin
                result = {{(`RV_XLEN-32){1'b0}}, sel[31:0]};
            end
            rv_wb_pkg::ext_half_s: begin
                result = {{(`RV_XLEN-16){sel[15]}}, sel[15:0]};
            end
            default: begin
                result = sel;
            end
        endcase
    end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_wb_params.svh"

module rv_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      we,
    input  logic [`RV_REG_ADDR_W-1:0] waddr,
    input  logic [`RV_XLEN-1:0]       wdata,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    input  logic [`RV_REG_ADDR_W-1:0] base_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data,
    output logic [`RV_XLEN-1:0]       base_data
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 reads as zero
    assign rs1_data  = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data  = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign base_data = (base_addr == '0) ? '0 : regs[base_addr];

    // retire control must already have filtered rd == 0
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> waddr != '0
    ) else $error("register file write issued to x0");

endmodule

// File: hdl/wb_store_axil.sv
`timescale 1ns/1ps
`include "rv_wb_params.svh"

module wb_store_axil (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [`RV_XLEN-1:0]      addr,
    input  logic [`RV_XLEN-1:0]      data,
    input  logic [`RV_XLEN/8-1:0]    strb,
    output logic                     busy,
    output logic                     err,
    output rv_wb_pkg::axil_aw_t      aw,
    input  logic                     aw_ready,
    output rv_wb_pkg::axil_w_t       w,
    input  logic                     w_ready,
    input  rv_wb_pkg::axil_b_t       b,
    output logic                     b_ready
);

    localparam logic [1:0] resp_okay = 2'b00;

    typedef enum logic [1:0] {
        s_idle,
        s_send, // aw and/or w still open
        s_resp  // waiting on b
    } state_e;

    state_e                state;
    logic                  aw_pend;
    logic                  w_pend;
    logic [`RV_XLEN-1:0]   addr_q;
    logic [`RV_XLEN-1:0]   data_q;
    logic [`RV_XLEN/8-1:0] strb_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= s_idle;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            err     <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state   <= s_send;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end
                end
                s_send: begin
                    if (aw_pend && aw_ready) aw_pend <= 1'b0;
                    if (w_pend && w_ready) w_pend <= 1'b0;
                    if ((!aw_pend || aw_ready) && (!w_pend || w_ready)) begin
                        state <= s_resp; // both beats gone
                    end
                end
                s_resp: begin
                    if (b.valid) begin
                        state <= s_idle;
                        if (b.resp != resp_okay) err <= 1'b1; // sticky
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
            data_q <= data;
            strb_q <= strb;
        end
    end

    assign busy     = (state != s_idle);
    assign b_ready  = (state == s_resp);
    assign aw.addr  = addr_q;
    assign aw.valid = aw_pend;
    assign w.data   = data_q;
    assign w.strb   = strb_q;
    assign w.valid  = w_pend;

    a_aw_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        aw.valid && !aw_ready |=> aw.valid && $stable(aw.addr)
    ) else $error("aw payload changed while waiting for aw_ready");

    a_w_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        w.valid && !w_ready |=> w.valid && $stable(w.data) && $stable(w.strb)
    ) else $error("w payload changed while waiting for w_ready");

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> !busy
    ) else $error("store started while previous store outstanding");

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/1ps
`include "rv_wb_params.svh"

module wb_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv_wb_pkg::wb_req_t        req,
    input  logic                      valid,
    output logic                      ready,
    input  logic [`RV_XLEN-1:0]       result,
    input  logic [`RV_XLEN-1:0]       base_data,
    output logic                      rf_we,
    output logic [`RV_REG_ADDR_W-1:0] rf_waddr,
    output logic [`RV_XLEN-1:0]       rf_wdata,
    output logic [`RV_REG_ADDR_W-1:0] base_addr,
    output logic                      st_start,
    output logic [`RV_XLEN-1:0]       st_addr,
    output logic [`RV_XLEN-1:0]       st_data,
    output logic [`RV_XLEN/8-1:0]     st_strb,
    input  logic                      st_busy,
    output logic                      halted,
    output logic [`RV_XLEN-1:0]       retired_pc
);

    logic                accept;
    logic [`RV_XLEN-1:0] imm_sext;

    assign ready  = !halted && !st_busy;
    assign accept = valid && ready;

    // register write path, x0 filtered here
    assign rf_we    = accept && req.op == rv_wb_pkg::op_reg_write && req.rd != '0;
    assign rf_waddr = req.rd;
    assign rf_wdata = result;

    // store address from base register
    assign base_addr = req.rs_base;
    assign imm_sext  = {{(`RV_XLEN-`RV_IMM_W){req.imm[`RV_IMM_W-1]}}, req.imm};
    assign st_start  = accept && req.op == rv_wb_pkg::op_store;
    assign st_addr   = base_data + imm_sext;
    assign st_data   = result;
    assign st_strb   = req.strb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (accept && req.op == rv_wb_pkg::op_ebreak) begin
            halted <= 1'b1; // held until reset
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired_pc <= '0;
        end else if (accept && req.op != rv_wb_pkg::op_nop) begin
            retired_pc <= req.pc;
        end
    end

    // producer may give up after a halt, but never changes a pending request
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid && !ready |=> !valid || $stable(req)
    ) else $error("retire request changed while waiting for ready");

endmodule

// File: hdl/rv_wb_top.sv
`timescale 1ns/1ps
`include "rv_wb_params.svh"

module rv_wb_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv_wb_pkg::wb_req_t        wb_req,
    input  logic                      wb_valid,
    output logic                      wb_ready,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data,
    output rv_wb_pkg::axil_aw_t       aw,
    input  logic                      aw_ready,
    output rv_wb_pkg::axil_w_t        w,
    input  logic                      w_ready,
    input  rv_wb_pkg::axil_b_t        b,
    output logic                      b_ready,
    output logic                      halted,
    output logic                      store_err,
    output logic [`RV_XLEN-1:0]       retired_pc
);

    logic [`RV_XLEN-1:0]       result;
    logic [`RV_XLEN-1:0]       base_data;
    logic [`RV_REG_ADDR_W-1:0] base_addr;
    logic                      rf_we;
    logic [`RV_REG_ADDR_W-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]       rf_wdata;
    logic                      st_start;
    logic [`RV_XLEN-1:0]       st_addr;
    logic [`RV_XLEN-1:0]       st_data;
    logic [`RV_XLEN/8-1:0]     st_strb;
    logic                      st_busy;

    wb_stage u_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (wb_req),
        .valid      (wb_valid),
        .ready      (wb_ready),
        .result     (result),
        .base_data  (base_data),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .base_addr  (base_addr),
        .st_start   (st_start),
        .st_addr    (st_addr),
        .st_data    (st_data),
        .st_strb    (st_strb),
        .st_busy    (st_busy),
        .halted     (halted),
        .retired_pc (retired_pc)
    );

    wb_extend u_extend (
        .src     (wb_req.src),
        .ext     (wb_req.ext),
        .alu_res (wb_req.alu_res),
        .mem_res (wb_req.mem_res),
        .result  (result)
    );

    rv_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (rf_we),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .base_addr (base_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .base_data (base_data)
    );

    wb_store_axil u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (st_start),
        .addr     (st_addr),
        .data     (st_data),
        .strb     (st_strb),
        .busy     (st_busy),
        .err      (store_err),
        .aw       (aw),
        .aw_ready (aw_ready),
        .w        (w),
        .w_ready  (w_ready),
        .b        (b),
        .b_ready  (b_ready)
    );

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: testbench/tb_rv_wb_top.sv
`timescale 1ns/1ps
`include "rv_wb_params.svh"

module tb_rv_wb_top;

    localparam int ready_timeout = 50; // cycles allowed per wait
    localparam int halt_cycles   = 20;

    typedef struct packed {
        rv_wb_pkg::wb_req_t  req;
        logic                slverr;   // memory answers SLVERR
        logic [`RV_XLEN-1:0] exp_data; // register value or store data
    } entry_t;

    logic                      clk;
    logic                      rst_n;
    rv_wb_pkg::wb_req_t        wb_req;
    logic                      wb_valid;
    logic                      wb_ready;
    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    rv_wb_pkg::axil_aw_t       aw;
    logic                      aw_ready;
    rv_wb_pkg::axil_w_t        w;
    logic                      w_ready;
    rv_wb_pkg::axil_b_t        b;
    logic                      b_ready;
    logic                      halted;
    logic                      store_err;
    logic [`RV_XLEN-1:0]       retired_pc;

    entry_t              table_q [$];
    logic [`RV_XLEN-1:0] model [0:`RV_REG_COUNT-1]; // reference register file
    logic [`RV_XLEN-1:0] exp_pc;
    logic                exp_err;
    logic                exp_halt;
    rv_wb_pkg::wb_req_t  blocked_req;
    integer              seed;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_wb_top dut0 (.*);

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        abort_run();
    endtask

    function automatic void add_entry(
        input rv_wb_pkg::wb_op_e op, input rv_wb_pkg::wb_src_e src,
        input rv_wb_pkg::wb_ext_e ext, input logic [4:0] rd, input logic [4:0] rs_base,
        input logic [31:0] imm, input logic [7:0] strb, input logic slverr,
        input logic [63:0] alu_res, input logic [63:0] mem_res, input logic [63:0] exp_data
    );
        entry_t e;
        e.req.op      = op;
        e.req.src     = src;
        e.req.ext     = ext;
        e.req.rd      = rd;
        e.req.rs_base = rs_base;
        e.req.imm     = imm;
        e.req.strb    = strb;
        e.req.alu_res = alu_res;
        e.req.mem_res = mem_res;
        e.req.pc      = 64'h1000 + 64'(table_q.size()) * 4; // one word per entry
        e.slverr      = slverr;
        e.exp_data    = exp_data;
        table_q.push_back(e);
    endfunction

    function automatic void build_table();
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_alu, rv_wb_pkg::ext_full,
            5'd1, 5'd0, 32'h0, 8'h00, 1'b0,
            64'h0123_4567_89ab_cdef, 64'hffff_eeee_dddd_cccc, 64'h0123_4567_89ab_cdef);
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_mem, rv_wb_pkg::ext_word_s,
            5'd2, 5'd0, 32'h0, 8'h00, 1'b0,
            64'h0, 64'h1111_2222_8765_4321, 64'hffff_ffff_8765_4321);
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_mem, rv_wb_pkg::ext_word_u,
            5'd3, 5'd0, 32'h0, 8'h00, 1'b0,
            64'h7777_7777_7777_7777, 64'hffff_0000_9abc_def0, 64'h0000_0000_9abc_def0);
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_alu, rv_wb_pkg::ext_half_s,
            5'd4, 5'd0, 32'h0, 8'h00, 1'b0,
            64'h0000_0000_1234_8001, 64'h0, 64'hffff_ffff_ffff_8001);
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_alu, rv_wb_pkg::ext_word_s,
            5'd5, 5'd0, 32'h0, 8'h00, 1'b0,
            64'hffff_ffff_7fff_0000, 64'h1, 64'h0000_0000_7fff_0000);
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_mem, rv_wb_pkg::ext_full,
            5'd6, 5'd0, 32'h0, 8'h00, 1'b0,
            64'hbad0, 64'h0000_0000_0000_1000, 64'h0000_0000_0000_1000);
        // x0 write is dropped
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_alu, rv_wb_pkg::ext_full,
            5'd0, 5'd0, 32'h0, 8'h00, 1'b0,
            64'hffff_ffff_ffff_ffff, 64'h0, 64'h0);
        add_entry(rv_wb_pkg::op_nop, rv_wb_pkg::src_alu, rv_wb_pkg::ext_full,
            5'd1, 5'd0, 32'h0, 8'h00, 1'b0,
            64'h5a5a_5a5a_5a5a_5a5a, 64'h0, 64'h0);
        add_entry(rv_wb_pkg::op_store, rv_wb_pkg::src_alu, rv_wb_pkg::ext_full,
            5'd0, 5'd6, 32'h0000_0040, 8'hff, 1'b0,
            64'hcafe_f00d_1234_5678, 64'h0, 64'hcafe_f00d_1234_5678);
        // negative offset, memory flags SLVERR
        add_entry(rv_wb_pkg::op_store, rv_wb_pkg::src_mem, rv_wb_pkg::ext_word_s,
            5'd0, 5'd6, 32'hffff_fff0, 8'h0f, 1'b1,
            64'h5555_5555_5555_5555, 64'h0000_0000_8000_0001, 64'hffff_ffff_8000_0001);
        add_entry(rv_wb_pkg::op_store, rv_wb_pkg::src_alu, rv_wb_pkg::ext_half_s,
            5'd0, 5'd1, 32'h0000_0008, 8'h03, 1'b0,
            64'hffff_ffff_0000_7abc, 64'h0, 64'h0000_0000_0000_7abc);
        // rd set on a store must not reach the register file
        add_entry(rv_wb_pkg::op_store, rv_wb_pkg::src_mem, rv_wb_pkg::ext_word_u,
            5'd5, 5'd0, 32'h8000_0000, 8'hf0, 1'b0,
            64'h0, 64'habcd_ef01_fedc_ba98, 64'h0000_0000_fedc_ba98);
        add_entry(rv_wb_pkg::op_reg_write, rv_wb_pkg::src_mem, rv_wb_pkg::ext_half_s,
            5'd7, 5'd0, 32'h0, 8'h00, 1'b0,
            64'hffff, 64'h1234_5678_9abc_7fff, 64'h0000_0000_0000_7fff);
        add_entry(rv_wb_pkg::op_ebreak, rv_wb_pkg::src_alu, rv_wb_pkg::ext_full,
            5'd0, 5'd0, 32'h0, 8'h00, 1'b0,
            64'h0, 64'h0, 64'h0);
    endfunction

    // returns just after the accepting edge
    task automatic wait_accept();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!wb_ready) begin
            cnt++;
            if (cnt > ready_timeout) report_timeout("wb_ready never rose for a pending request");
            @(negedge clk);
        end
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    // AXI4-Lite slave side for one store, random ready delays
    task automatic serve_store(input logic slverr, output logic [63:0] addr,
                               output logic [63:0] data, output logic [7:0] strb);
        logic aw_done;
        logic w_done;
        int   cnt;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cnt     = 0;
        aw_ready <= ($random(seed) & 1) != 0;
        w_ready  <= ($random(seed) & 1) != 0;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            check_val("wb_ready", wb_ready, 1'b0);
            if (aw_done) check_val("aw.valid", aw.valid, 1'b0); // one beat only
            if (w_done) check_val("w.valid", w.valid, 1'b0);
            if (!aw_done && aw.valid && aw_ready) begin
                addr    = aw.addr;
                aw_done = 1'b1;
            end
            if (!w_done && w.valid && w_ready) begin
                data   = w.data;
                strb   = w.strb;
                w_done = 1'b1;
            end
            cnt++;
            if (cnt > ready_timeout) report_timeout("AW or W beat of a store never arrived");
            @(posedge clk);
            aw_ready <= !aw_done && (($random(seed) & 1) != 0);
            w_ready  <= !w_done && (($random(seed) & 1) != 0);
        end
        repeat ($random(seed) & 3) begin // response latency
            @(negedge clk);
            check_val("wb_ready", wb_ready, 1'b0);
            @(posedge clk);
        end
        b.resp  <= slverr ? 2'b10 : 2'b00;
        b.valid <= 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            check_val("wb_ready", wb_ready, 1'b0);
            cnt++;
            if (!b_ready && cnt > ready_timeout) report_timeout("b_ready never rose");
        end while (!b_ready);
        @(posedge clk);
        b.valid <= 1'b0;
        b.resp  <= 2'b00;
        @(negedge clk);
        check_val("wb_ready", wb_ready, 1'b1); // free again after B
    endtask

    task automatic compare_regs();
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            @(posedge clk);
            rs2_addr <= i[`RV_REG_ADDR_W-1:0];
            @(negedge clk);
            check_val($sformatf("rs2_data (x%0d)", i), rs2_data, model[i]);
        end
    endtask

    task automatic run_entry(input entry_t e);
        logic [63:0] got_addr;
        logic [63:0] got_data;
        logic [7:0]  got_strb;
        logic [63:0] exp_addr;
        @(posedge clk);
        wb_req   <= e.req;
        wb_valid <= 1'b1;
        rs1_addr <= e.req.rd;
        wait_accept();
        case (e.req.op)
            rv_wb_pkg::op_reg_write: begin
                if (e.req.rd != 0) model[e.req.rd] = e.exp_data;
                @(negedge clk);
                check_val("rs1_data", rs1_data, model[e.req.rd]);
            end
            rv_wb_pkg::op_store: begin
                exp_addr = model[e.req.rs_base] + {{32{e.req.imm[31]}}, e.req.imm};
                exp_err  = exp_err | e.slverr;
                serve_store(e.slverr, got_addr, got_data, got_strb);
                check_val("aw.addr", got_addr, exp_addr);
                check_val("w.data", got_data, e.exp_data);
                check_val("w.strb", got_strb, e.req.strb);
            end
            default: begin
                @(negedge clk);
            end
        endcase
        if (e.req.op != rv_wb_pkg::op_nop) exp_pc = e.req.pc;
        if (e.req.op == rv_wb_pkg::op_ebreak) exp_halt = 1'b1;
        check_val("retired_pc", retired_pc, exp_pc);
        check_val("store_err", store_err, exp_err);
        check_val("halted", halted, exp_halt);
        compare_regs();
    endtask

    initial begin
        int cnt;
        seed     = 32'hb60805ef;
        wb_req   = '0;
        wb_valid = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b        = '0;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            model[i] = '0;
        end
        exp_pc   = '0;
        exp_err  = 1'b0;
        exp_halt = 1'b0;
        build_table();

        cnt = 0;
        while (!rst_n) begin
            @(posedge clk);
            cnt++;
            if (cnt > 20) report_timeout("reset was never released");
        end

        // state right after reset
        @(negedge clk);
        check_val("wb_ready", wb_ready, 1'b1);
        check_val("aw.valid", aw.valid, 1'b0);
        check_val("w.valid", w.valid, 1'b0);
        check_val("b_ready", b_ready, 1'b0);
        check_val("halted", halted, 1'b0);
        check_val("store_err", store_err, 1'b0);
        check_val("retired_pc", retired_pc, 64'h0);
        compare_regs();

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end

        // request after ebreak must stall
        blocked_req         = table_q[0].req;
        blocked_req.alu_res = ~blocked_req.alu_res;
        @(posedge clk);
        wb_req   <= blocked_req;
        wb_valid <= 1'b1;
        repeat (halt_cycles) begin
            @(negedge clk);
            check_val("wb_ready", wb_ready, 1'b0);
            check_val("halted", halted, 1'b1);
            @(posedge clk);
        end
        wb_valid <= 1'b0;
        compare_regs();
        check_val("retired_pc", retired_pc, exp_pc);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: sim.f
+incdir+hdl
hdl/rv_wb_pkg.sv
hdl/wb_extend.sv
hdl/rv_regfile.sv
hdl/wb_store_axil.sv
hdl/wb_stage.sv
hdl/rv_wb_top.sv
testbench/tb_clkgen.sv
testbench/tb_rv_wb_top.sv

// File: Bender.yml
package:
  name: rv_wb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_wb_pkg.sv
      - hdl/wb_extend.sv
      - hdl/rv_regfile.sv
      - hdl/wb_store_axil.sv
      - hdl/wb_stage.sv
      - hdl/rv_wb_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_clkgen.sv
      - testbench/tb_rv_wb_top.sv
